// File: build.f
+incdir+tb
verilog/ice_app_pkg.sv
verilog/spi_msg_rx.sv
verilog/spi_cmd_decoder.sv
verilog/spi_resp_tx.sv
verilog/sd_cmd6_capture.sv
verilog/ice_app.sv
tb/ice_app_tb.sv

// File: tb/ice_app_tb_tasks.svh
// ============================================================
// Value checking
// ============================================================
task automatic compare_value(input string name, input logic [63:0] exp,
                             input logic [63:0] got);
    check_cnt++;
    if (got !== exp) begin
        error_cnt++;
        $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, got);
    end
endtask

// Line must stay released and led unchanged
task automatic expect_quiet(input int cycles, input logic [3:0] led_exp);
    repeat (cycles) begin
        compare_value("data_oe", 64'h0, data_oe);
        compare_value("led", led_exp, led);
        @(posedge sd_datInWrite_clk);
        #1;
    end
endtask

// ============================================================
// Serial frames
// ============================================================
task automatic send_msg(input logic [ice_app_pkg::msg_len-1:0] frame);
    int i;
    data_in = 1'b1;                             // Start bit
    for (i = ice_app_pkg::msg_len - 1; i >= 0; i--) begin
        @(posedge sd_datInWrite_clk);
        #1;
        data_in = frame[i];                     // MSB first
    end
    @(posedge sd_datInWrite_clk);               // Samples the last bit
    #1;
    data_in = 1'b0;
endtask

task automatic recv_resp(output logic [ice_app_pkg::resp_len-1:0] word);
    int i;
    word = '0;
    for (i = 0; i < ice_app_pkg::turnaround_cycles; i++) begin
        compare_value("data_oe", 64'h0, data_oe);
        @(posedge sd_datInWrite_clk);
        #1;
    end
    check_cnt++;
    if (data_oe !== 1'b1) begin
        error_cnt++;
        $display("Error at %0t ns: data_oe did not rise after the turnaround", $time);
    end else begin
        for (i = ice_app_pkg::resp_len - 1; i >= 0; i--) begin
            compare_value("data_oe", 64'h1, data_oe);
            word[i] = data_out;
            @(posedge sd_datInWrite_clk);
            #1;
        end
        compare_value("data_oe", 64'h0, data_oe);   // Released after the last bit
    end
endtask

// ============================================================
// DatIn stream
// ============================================================
task automatic send_datin_block(input int words);
    int i;
    datin_rst = 1'b1;
    @(posedge sd_datInWrite_clk);
    #1;
    datin_rst = 1'b0;
    for (i = 0; i < words; i++) begin
        datin_trigger = 1'b1;
        datin_data    = datin_words[i];
        @(posedge sd_datInWrite_clk);
        #1;
    end
    datin_trigger = 1'b0;
endtask

// File: tb/ice_app_tb.sv
module ice_app_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int timeout_cycles = 3000;       // ~12 frames of 140 cycles plus DatIn

    logic        sd_datInWrite_clk = 1'b0;
    logic        spi_rst_;
    logic        data_in;
    logic        datin_rst;
    logic        datin_trigger;
    logic [15:0] datin_data;
    logic        data_out;
    logic        data_oe;
    logic [3:0]  led;

    logic [15:0] datin_words [0:ice_app_pkg::datin_block_words-1];
    logic [3:0]  led_now = 4'h0;                // Last value written by LEDSet
    int unsigned rand_seed = 32'h376301ca;
    int          check_cnt = 0;
    int          error_cnt = 0;
    int          cycle_cnt = 0;

    `include "ice_app_tb_tasks.svh"

    ice_app u_dut (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .data_in           (data_in),
        .datin_rst         (datin_rst),
        .datin_trigger     (datin_trigger),
        .datin_data        (datin_data),
        .data_out          (data_out),
        .data_oe           (data_oe),
        .led               (led)
    );

    always #4 sd_datInWrite_clk = ~sd_datInWrite_clk;

    always @(posedge sd_datInWrite_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("Timeout: run stopped after %0d cycles", cycle_cnt);
            $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ============================================================
    // Directed tests
    // ============================================================
    task automatic echo_roundtrip(input logic [55:0] payload);
        logic [63:0] resp;
        send_msg({ice_app_pkg::msg_type_echo, payload});
        recv_resp(resp);
        compare_value("data_out word", {payload, 8'h00}, resp);
    endtask

    task automatic led_update(input logic [3:0] val);
        logic [51:0] pad;
        pad = 52'({$urandom, $urandom});
        send_msg({ice_app_pkg::msg_type_led_set, pad, val});
        compare_value("led", led_now, led);
        @(posedge sd_datInWrite_clk);
        #1;
        compare_value("led", led_now, led);     // Still old one edge after
        @(posedge sd_datInWrite_clk);
        #1;
        led_now = val;
        expect_quiet(ice_app_pkg::turnaround_cycles + 4, led_now);
    endtask

    // Echo follows the LEDSet frame with no gap
    task automatic led_then_echo(input logic [3:0] val, input logic [55:0] payload);
        logic [63:0] resp;
        send_msg({ice_app_pkg::msg_type_led_set, 52'h0, val});
        send_msg({ice_app_pkg::msg_type_echo, payload});
        recv_resp(resp);
        compare_value("data_out word", {payload, 8'h00}, resp);
        led_now = val;
        compare_value("led", led_now, led);
    endtask

    task automatic cmd6_status();
        logic [63:0] resp;
        logic [3:0]  mode;
        int          i;
        for (i = 0; i < ice_app_pkg::datin_block_words; i++) begin
            datin_words[i] = 16'($urandom);
        end
        send_datin_block(ice_app_pkg::datin_block_words);
        mode = datin_words[ice_app_pkg::cmd6_mode_word][ice_app_pkg::cmd6_mode_lsb +: 4];
        send_msg({ice_app_pkg::msg_type_sd_status, 56'h0});
        recv_resp(resp);
        compare_value("data_out word", {mode, 1'b1, 59'h0}, resp);
        // Partial block with a new mode forced to differ
        for (i = 0; i < 10; i++) begin
            datin_words[i] = 16'($urandom);
        end
        datin_words[ice_app_pkg::cmd6_mode_word][ice_app_pkg::cmd6_mode_lsb +: 4] = ~mode;
        send_datin_block(10);
        send_msg({ice_app_pkg::msg_type_sd_status, 56'h0});
        recv_resp(resp);
        compare_value("data_out word", {~mode, 1'b0, 59'h0}, resp);
    endtask

    task automatic ignored_types();
        logic [51:0] pad;
        int          quiet;
        pad   = 52'({$urandom, $urandom});
        quiet = ice_app_pkg::turnaround_cycles + ice_app_pkg::resp_len + 4;
        send_msg({ice_app_pkg::msg_type_nop, pad, ~led_now});
        expect_quiet(quiet, led_now);
        send_msg({8'h05, pad, ~led_now});       // Unknown code
        expect_quiet(quiet, led_now);
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        logic [63:0] resp;
        int          i;
        spi_rst_      = 1'b0;
        data_in       = 1'b0;
        datin_rst     = 1'b0;
        datin_trigger = 1'b0;
        datin_data    = 16'h0;
        void'($urandom(rand_seed));
        repeat (3) @(posedge sd_datInWrite_clk);
        #1;
        spi_rst_ = 1'b1;

        compare_value("led", 64'h0, led);
        compare_value("data_oe", 64'h0, data_oe);
        send_msg({ice_app_pkg::msg_type_sd_status, 56'h0});
        recv_resp(resp);
        compare_value("data_out word", 64'h0, resp);   // Mode 0 and block not done

        for (i = 0; i < 3; i++) begin
            echo_roundtrip(56'({$urandom, $urandom}));
        end
        led_update(4'h5);
        led_update(4'hA);
        led_update(4'h3);
        led_then_echo(4'hC, 56'({$urandom, $urandom}));
        cmd6_status();
        ignored_types();

        $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/ice_app.sv
module ice_app (
    input  logic        sd_datInWrite_clk,
    input  logic        spi_rst_,
    input  logic        data_in,
    input  logic        datin_rst,
    input  logic        datin_trigger,
    input  logic [15:0] datin_data,
    output logic        data_out,
    output logic        data_oe,
    output logic [3:0]  led
);

    ice_app_pkg::msg_t                  msg;
    logic                               msg_valid;
    logic [ice_app_pkg::resp_len-1:0]   resp_word;
    logic                               resp_start;
    logic                               tx_busy;
    logic [3:0]                         access_mode;
    logic                               block_done;

    // ============================================================
    // Serial command port
    // ============================================================
    spi_msg_rx u_msg_rx (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .data_in           (data_in),
        .tx_busy           (tx_busy),
        .msg               (msg),
        .msg_valid         (msg_valid)
    );

    spi_cmd_decoder u_cmd_decoder (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .msg               (msg),
        .msg_valid         (msg_valid),
        .access_mode       (access_mode),
        .block_done        (block_done),
        .resp_word         (resp_word),
        .resp_start        (resp_start),
        .led               (led)
    );

    spi_resp_tx u_resp_tx (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .resp_word         (resp_word),
        .resp_start        (resp_start),
        .data_out          (data_out),
        .data_oe           (data_oe),
        .tx_busy           (tx_busy)
    );

    // ============================================================
    // CMD6 status capture
    // ============================================================
    sd_cmd6_capture u_cmd6_capture (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .datin_rst         (datin_rst),
        .datin_trigger     (datin_trigger),
        .datin_data        (datin_data),
        .access_mode       (access_mode),
        .block_done        (block_done)
    );

endmodule

// File: verilog/ice_app_pkg.sv
package ice_app_pkg;

    // ============================================================
    // Serial message and response layout
    // ============================================================
    localparam int msg_len            = 64;
    localparam int msg_type_len       = 8;
    localparam int msg_arg_len        = 56;
    localparam int resp_len           = 64;
    localparam int turnaround_cycles  = 8;   // Last message bit to first response bit
    localparam int msg_type_resp_bit  = 7;   // Set when the host expects a response

    // Edges from the last message bit until the transmitter holds its word, plus one
    localparam int resp_pipe_cycles   = 4;

    // Type codes
    localparam logic [msg_type_len-1:0] msg_type_nop       = 8'h00;
    localparam logic [msg_type_len-1:0] msg_type_echo      = 8'h80;
    localparam logic [msg_type_len-1:0] msg_type_led_set   = 8'h01;
    localparam logic [msg_type_len-1:0] msg_type_sd_status = 8'h82;

    // ============================================================
    // CMD6 status block
    // ============================================================
    localparam int datin_block_words  = 32;
    localparam int cmd6_mode_word     = 8;   // Word that carries the access mode
    localparam int cmd6_mode_lsb      = 8;

    // Counter widths and their typed load / compare values
    localparam int msg_cnt_w   = $clog2(msg_len);
    localparam int resp_cnt_w  = $clog2(resp_len);
    localparam int ta_cnt_w    = $clog2(turnaround_cycles);
    localparam int datin_cnt_w = $clog2(datin_block_words);

    localparam logic [msg_cnt_w-1:0]   msg_cnt_init   = msg_cnt_w'(msg_len - 1);
    localparam logic [resp_cnt_w-1:0]  resp_cnt_init  = resp_cnt_w'(resp_len - 1);
    localparam logic [ta_cnt_w-1:0]    ta_wait_init   =
        ta_cnt_w'(turnaround_cycles - resp_pipe_cycles);
    localparam logic [datin_cnt_w-1:0] datin_mode_idx = datin_cnt_w'(cmd6_mode_word);
    localparam logic [datin_cnt_w-1:0] datin_last_idx = datin_cnt_w'(datin_block_words - 1);

    // ============================================================
    // Message word
    // ============================================================
    // Argument seen as Echo payload or as the LEDSet field
    typedef union packed {
        logic [msg_arg_len-1:0] echo;
        struct packed {
            logic [msg_arg_len-5:0] unused;
            logic [3:0]             led_val;
        } led_set;
    } msg_arg_t;

    typedef struct packed {
        logic [msg_type_len-1:0] msg_type;  // Sent first
        msg_arg_t                arg;
    } msg_t;

endpackage

// File: verilog/sd_cmd6_capture.sv
module sd_cmd6_capture (
    input  logic        sd_datInWrite_clk,
    input  logic        spi_rst_,
    input  logic        datin_rst,
    input  logic        datin_trigger,
    input  logic [15:0] datin_data,
    output logic [3:0]  access_mode,
    output logic        block_done
);

    logic [ice_app_pkg::datin_cnt_w-1:0] word_cnt;
    logic                                take_word;

    // Words past the end of the block are dropped
    assign take_word = datin_trigger && !block_done;

    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            word_cnt    <= '0;
            block_done  <= 1'b0;
            access_mode <= '0;
        end else if (datin_rst) begin
            word_cnt   <= '0;
            block_done <= 1'b0;                 // Mode kept until the next word 8
        end else if (take_word) begin
            word_cnt <= word_cnt + 1'b1;
            if (word_cnt == ice_app_pkg::datin_mode_idx) begin
                access_mode <= datin_data[ice_app_pkg::cmd6_mode_lsb +: 4];
            end
            if (word_cnt == ice_app_pkg::datin_last_idx) begin
                block_done <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/spi_cmd_decoder.sv
module spi_cmd_decoder (
    input  logic                              sd_datInWrite_clk,
    input  logic                              spi_rst_,
    input  ice_app_pkg::msg_t                 msg,
    input  logic                              msg_valid,
    input  logic [3:0]                        access_mode,
    input  logic                              block_done,
    output logic [ice_app_pkg::resp_len-1:0]  resp_word,
    output logic                              resp_start,
    output logic [3:0]                        led
);

    logic is_echo;
    logic is_led_set;
    logic is_sd_status;
    logic wants_resp;

    // ============================================================
    // Type decode
    // ============================================================
    always_comb begin
        is_echo      = 1'b0;
        is_led_set   = 1'b0;
        is_sd_status = 1'b0;
        case (msg.msg_type)
            ice_app_pkg::msg_type_echo: begin
                is_echo = 1'b1;
            end
            ice_app_pkg::msg_type_led_set: begin
                is_led_set = 1'b1;
            end
            ice_app_pkg::msg_type_sd_status: begin
                is_sd_status = 1'b1;
            end
            ice_app_pkg::msg_type_nop: begin
                is_echo = 1'b0;                 // Accepted with no action
            end
            default: begin
                is_echo = 1'b0;                 // Unknown codes dropped silently
            end
        endcase
    end

    // Both response types carry the response bit in their code
    assign wants_resp = is_echo || is_sd_status;

    // ============================================================
    // LED register and response strobe
    // ============================================================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            led        <= '0;
            resp_start <= 1'b0;
        end else begin
            resp_start <= msg_valid && wants_resp;
            if (msg_valid && is_led_set) begin
                led <= msg.arg.led_set.led_val;
            end
        end
    end

    // ============================================================
    // Response word
    // ============================================================
    always_ff @(posedge sd_datInWrite_clk) begin
        if (msg_valid && is_echo) begin
            // Payload in the top bits over a zero low byte
            resp_word <= {msg.arg.echo,
                          {(ice_app_pkg::resp_len - ice_app_pkg::msg_arg_len){1'b0}}};
        end else if (msg_valid && is_sd_status) begin
            resp_word <= {access_mode, block_done,
                          {(ice_app_pkg::resp_len - 5){1'b0}}};
        end
    end

endmodule

// File: verilog/spi_msg_rx.sv
module spi_msg_rx (
    input  logic              sd_datInWrite_clk,
    input  logic              spi_rst_,
    input  logic              data_in,
    input  logic              tx_busy,
    output ice_app_pkg::msg_t msg,
    output logic              msg_valid
);

    logic                                    shifting;
    logic [ice_app_pkg::msg_cnt_w-1:0]       bit_cnt;
    logic [ice_app_pkg::msg_len-1:0]         shift_q;
    logic [ice_app_pkg::msg_len-1:0]         next_word;
    ice_app_pkg::msg_t                       next_msg;
    logic                                    last_bit;
    logic                                    valid_pend;
    logic [1:0]                              hold_q;   // Covers the gap before tx_busy rises
    logic                                    blocked;

    assign next_word = {shift_q[ice_app_pkg::msg_len-2:0], data_in};
    assign next_msg  = next_word;
    assign last_bit  = shifting && (bit_cnt == '0);
    assign blocked   = tx_busy || (|hold_q);

    // ============================================================
    // Frame control
    // ============================================================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            shifting   <= 1'b0;
            bit_cnt    <= '0;
            valid_pend <= 1'b0;
            msg_valid  <= 1'b0;
            hold_q     <= '0;
        end else begin
            valid_pend <= last_bit;
            msg_valid  <= valid_pend;
            // Response types keep the line closed until the transmitter takes over
            hold_q <= {hold_q[0],
                       last_bit && next_msg.msg_type[ice_app_pkg::msg_type_resp_bit]};

            if (!shifting) begin
                if (data_in && !blocked) begin  // Start bit
                    shifting <= 1'b1;
                    bit_cnt  <= ice_app_pkg::msg_cnt_init;
                end
            end else if (bit_cnt == '0) begin
                shifting <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

    // ============================================================
    // Message payload
    // ============================================================
    always_ff @(posedge sd_datInWrite_clk) begin
        if (shifting) begin
            shift_q <= next_word;               // MSB first
        end
        if (valid_pend) begin
            msg <= shift_q;
        end
    end

endmodule

// File: verilog/spi_resp_tx.sv
module spi_resp_tx (
    input  logic                              sd_datInWrite_clk,
    input  logic                              spi_rst_,
    input  logic [ice_app_pkg::resp_len-1:0]  resp_word,
    input  logic                              resp_start,
    output logic                              data_out,
    output logic                              data_oe,
    output logic                              tx_busy
);

    logic                                   waiting;   // Turnaround in progress
    logic [ice_app_pkg::ta_cnt_w-1:0]       wait_cnt;
    logic [ice_app_pkg::resp_cnt_w-1:0]     bit_cnt;
    logic [ice_app_pkg::resp_len-1:0]       shift_q;

    assign data_out = shift_q[ice_app_pkg::resp_len-1];

    // Drops one cycle early so the receiver can take a start bit as data_oe falls
    assign tx_busy = resp_start || waiting || (data_oe && (bit_cnt != '0));

    // ============================================================
    // Turnaround and shift control
    // ============================================================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            waiting  <= 1'b0;
            wait_cnt <= '0;
            data_oe  <= 1'b0;
            bit_cnt  <= '0;
        end else if (resp_start) begin
            waiting  <= 1'b1;
            wait_cnt <= ice_app_pkg::ta_wait_init;
        end else if (waiting) begin
            if (wait_cnt == '0) begin
                waiting <= 1'b0;
                data_oe <= 1'b1;                // Bit 63 already on data_out
                bit_cnt <= ice_app_pkg::resp_cnt_init;
            end else begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end else if (data_oe) begin
            if (bit_cnt == '0) begin
                data_oe <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

    // ============================================================
    // Response shifter
    // ============================================================
    always_ff @(posedge sd_datInWrite_clk) begin
        if (resp_start) begin
            shift_q <= resp_word;
        end else if (data_oe && (bit_cnt != '0)) begin
            shift_q <= {shift_q[ice_app_pkg::resp_len-2:0], 1'b0};
        end
    end

endmodule
